// ==== hw/converterIo.sv ====
/*
 * ADC input reclocking and the three DAC output registers. Each DAC word
 * is the upper sample bits in offset binary, loaded on its sync.
 */
module converterIo (
  input  logic ck933,
  input  logic rs,
  input  logic [13:0] adcD,
  output logic [13:0] ifSample,
  input  demodCtrlPkg::demodSamples_t samples,
  output logic [2:0][13:0] dacD
);

  localparam int MsbPos = demodCtrlPkg::SampleWidth - 1;
  localparam int LsbPos = demodCtrlPkg::SampleWidth - demodCtrlPkg::AdcWidth;

  // Single register stage meant for the input pads
  always_ff @(posedge ck933) begin
    ifSample <= adcD;
  end

  // ********************
  // DAC words
  // ********************
  for (genvar i = 0; i < demodCtrlPkg::DacCount; i++) begin : gDac
    always_ff @(posedge ck933 or posedge rs) begin
      if (rs) begin
        // Midscale keeps the DAC output quiet
        dacD[i] <= 14'h2000;
      end else if (samples.sync[i]) begin
        dacD[i] <= {~samples.sample[i][MsbPos], samples.sample[i][MsbPos-1:LsbPos]};
      end
    end
  end

endmodule

// ==== hw/dacSpiSequencer.sv ====
/*
 * Runs one three-wire serial frame to the selected DAC. Holds the frame,
 * channel and read-back registers and reports busy in the status word.
 */
module dacSpiSequencer (
  input  logic ck933,
  input  logic rs,
  input  demodCtrlPkg::regWrite_t regWrite,
  input  demodCtrlPkg::addrSpace_e space,
  input  logic sdioIn,
  output logic [2:0] csN,
  output logic sclk,
  output logic sdioOut,
  output logic sdioOe,
  output logic [15:0] statusRd
);

  localparam int BitCntWidth = $clog2(demodCtrlPkg::SpiFrameBits);
  localparam int HalfFrame = demodCtrlPkg::SpiFrameBits / 2;

  demodCtrlPkg::spiState_e state;
  demodCtrlPkg::spiFrame_t frameReg;
  logic readFrame;
  logic [BitCntWidth-1:0] bitCnt;
  logic [7:0] readBack;
  logic [7:0] readByte;
  logic dacWrite;
  logic startReq;
  logic load;
  logic run;
  logic busy;
  logic shiftTick;
  logic sampleTick;
  logic lastHalf;
  logic captureEn;

  assign dacWrite = regWrite.strobe && (space == demodCtrlPkg::SpaceDac);
  // Channel 3 does not exist
  assign startReq = dacWrite && (regWrite.addr == demodCtrlPkg::DacCtrlAddr) &&
                    (regWrite.data[1:0] != 2'd3);
  assign busy = (state != demodCtrlPkg::SpiIdle);
  assign load = startReq && !busy;
  assign run = (state == demodCtrlPkg::SpiShift);
  assign lastHalf = (bitCnt >= BitCntWidth'(HalfFrame));
  assign captureEn = run && readFrame && lastHalf;

  // Hand sdio to the DAC for the data byte of a read frame
  assign sdioOe = (state == demodCtrlPkg::SpiSelect || run) && !(readFrame && lastHalf);
  assign statusRd = {readBack, 7'b0, busy};

  always_ff @(posedge ck933) begin
    if (dacWrite && regWrite.addr == demodCtrlPkg::DacFrameAddr) begin
      frameReg <= regWrite.data;
    end
  end

  // ********************
  // Frame FSM
  // ********************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      state <= demodCtrlPkg::SpiIdle;
      csN <= '1;
      readFrame <= 1'b0;
      bitCnt <= '0;
      readBack <= '0;
    end else begin
      case (state)
        demodCtrlPkg::SpiIdle: begin
          if (load) begin
            readFrame <= frameReg.rw;
            csN <= ~(3'b001 << regWrite.data[1:0]);
            state <= demodCtrlPkg::SpiSelect;
          end
        end
        demodCtrlPkg::SpiSelect: begin
          bitCnt <= '0;
          state <= demodCtrlPkg::SpiShift;
        end
        demodCtrlPkg::SpiShift: begin
          if (shiftTick) begin
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == BitCntWidth'(demodCtrlPkg::SpiFrameBits - 1)) begin
              state <= demodCtrlPkg::SpiRelease;
            end
          end
        end
        default: begin
          // sclk is low here, so csN rises with the clock idle
          if (readFrame) readBack <= readByte;
          csN <= '1;
          state <= demodCtrlPkg::SpiIdle;
        end
      endcase
    end
  end

  spiBitTimer bitTimer (
    .ck933(ck933),
    .rs(rs),
    .run(run),
    .sclk(sclk),
    .shiftTick(shiftTick),
    .sampleTick(sampleTick)
  );

  spiShifter shifter (
    .ck933(ck933),
    .rs(rs),
    .load(load),
    .frame(frameReg),
    .shiftTick(shiftTick),
    .sampleTick(sampleTick),
    .captureEn(captureEn),
    .sdioIn(sdioIn),
    .sdioOut(sdioOut),
    .readByte(readByte)
  );

  assert property (@(posedge ck933) disable iff (rs) $onehot0(~csN));

  // Chip select moves only with the serial clock low on both sides
  assert property (@(posedge ck933) disable iff (rs)
    !$stable(csN) |-> !sclk && !$past(sclk));

endmodule

// ==== hw/demodCtrlPkg.sv ====
/*
 * Shared address map, widths, bus structs and state enums for the
 * demodulator host control subsystem. Referenced by scoped name only.
 */
package demodCtrlPkg;

  // ********************
  // Widths and constants
  // ********************
  localparam logic [15:0] VerNumber = 16'h0003;
  localparam int AddrWidth = 12;
  localparam int DataWidth = 16;
  localparam int ResetHoldCycles = 5;
  localparam int SpiFrameBits = 16;
  localparam int DacCount = 3;
  localparam int AdcWidth = 14;
  localparam int SampleWidth = 18;

  // Register addresses
  localparam logic [AddrWidth-1:0] MiscResetAddr = 12'h000;
  localparam logic [AddrWidth-1:0] MiscVersionAddr = 12'h002;
  localparam logic [AddrWidth-1:0] DacFrameAddr = 12'h100;
  localparam logic [AddrWidth-1:0] DacCtrlAddr = 12'h102;
  localparam logic [AddrWidth-1:0] GpioAddr = 12'h200;

  // Address space bounds, inclusive
  localparam logic [AddrWidth-1:0] MiscSpaceLo = 12'h000;
  localparam logic [AddrWidth-1:0] MiscSpaceHi = 12'h0FE;
  localparam logic [AddrWidth-1:0] DacSpaceLo = 12'h100;
  localparam logic [AddrWidth-1:0] DacSpaceHi = 12'h1FE;
  localparam logic [AddrWidth-1:0] GpioSpaceLo = 12'h200;
  localparam logic [AddrWidth-1:0] GpioSpaceHi = 12'h2FE;
  localparam logic [AddrWidth-1:0] DemodSpaceLo = 12'h800;
  localparam logic [AddrWidth-1:0] DemodSpaceHi = 12'hFFE;

  // ********************
  // Enums
  // ********************
  typedef enum logic [2:0] {
    SpaceMisc, SpaceDac, SpaceGpio, SpaceDemod, SpaceNone
  } addrSpace_e;

  typedef enum logic [1:0] {
    SpiIdle, SpiSelect, SpiShift, SpiRelease
  } spiState_e;

  // ********************
  // Structs
  // ********************
  // Host pins, all strobes active low
  typedef struct packed {
    logic nCs;
    logic nWe;
    logic nRd;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wrData;
  } hostBus_t;

  typedef struct packed {
    logic strobe;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
  } regWrite_t;

  // Sent MSB first, so rw goes out on the first sclk
  typedef struct packed {
    logic rw;
    logic [1:0] width;
    logic [4:0] regAddr;
    logic [7:0] regData;
  } spiFrame_t;

  typedef struct packed {
    logic [DacCount-1:0][SampleWidth-1:0] sample;
    logic [DacCount-1:0] sync;
  } demodSamples_t;

endpackage

// ==== hw/demodCtrlTop.sv ====
/*
 * Host control subsystem top level. Connects the bus decoder, reset
 * stretcher, DAC serial port, converter paths and GPIO.
 */
module demodCtrlTop (
  input  logic ck933,
  input  logic rs,
  input  demodCtrlPkg::hostBus_t hostBus,
  output logic [15:0] rdData,
  output logic rdOe,
  input  logic [13:0] adcD,
  output logic [13:0] ifSample,
  input  demodCtrlPkg::demodSamples_t samples,
  output logic [2:0][13:0] dacD,
  output logic dacRst,
  output logic [2:0] csN,
  output logic sclk,
  input  logic sdioIn,
  output logic sdioOut,
  output logic sdioOe,
  output logic bsyncNLock,
  output logic demodNLock,
  output demodCtrlPkg::regWrite_t demodWrite,
  input  logic [31:0] demodRdData
);

  demodCtrlPkg::regWrite_t regWrite;
  demodCtrlPkg::addrSpace_e space;
  logic softReset;
  logic intReset;
  logic [15:0] dacRdData;
  logic [15:0] gpioRdData;

  hostBusDecoder busDecoder (
    .ck933(ck933), .rs(rs), .hostBus(hostBus),
    .dacRdData(dacRdData), .gpioRdData(gpioRdData), .demodRdData(demodRdData),
    .regWrite(regWrite), .space(space), .softReset(softReset),
    .rdData(rdData), .rdOe(rdOe)
  );

  resetStretcher resetHold (
    .ck933(ck933), .rs(rs), .softReset(softReset), .intReset(intReset)
  );

  assign dacRst = intReset;

  // ********************
  // Internal reset domain
  // ********************
  dacSpiSequencer dacSpi (
    .ck933(ck933), .rs(intReset), .regWrite(regWrite), .space(space),
    .sdioIn(sdioIn), .csN(csN), .sclk(sclk), .sdioOut(sdioOut),
    .sdioOe(sdioOe), .statusRd(dacRdData)
  );

  converterIo convIo (
    .ck933(ck933), .rs(intReset), .adcD(adcD), .ifSample(ifSample),
    .samples(samples), .dacD(dacD)
  );

  statusGpio gpio (
    .ck933(ck933), .rs(intReset), .regWrite(regWrite), .space(space),
    .gpioRdData(gpioRdData), .bsyncNLock(bsyncNLock), .demodNLock(demodNLock)
  );

  // Demod register writes leave the chip unchanged
  assign demodWrite.strobe = regWrite.strobe && (space == demodCtrlPkg::SpaceDemod);
  assign demodWrite.addr = regWrite.addr;
  assign demodWrite.data = regWrite.data;

endmodule

// ==== hw/hostBusDecoder.sv ====
/*
 * Samples the chip-select host bus on ck933, turns writes into one-cycle
 * strobes, decodes the address space and registers the read data mux.
 */
module hostBusDecoder (
  input  logic ck933,
  input  logic rs,
  input  demodCtrlPkg::hostBus_t hostBus,
  input  logic [15:0] dacRdData,
  input  logic [15:0] gpioRdData,
  input  logic [31:0] demodRdData,
  output demodCtrlPkg::regWrite_t regWrite,
  output demodCtrlPkg::addrSpace_e space,
  output logic softReset,
  output logic [15:0] rdData,
  output logic rdOe
);

  demodCtrlPkg::hostBus_t busQ;
  demodCtrlPkg::addrSpace_e busSpace;
  logic wrSampled;
  logic wrPrev;
  logic rdSampled;
  logic [15:0] rdMux;

  function automatic demodCtrlPkg::addrSpace_e decodeSpace(
    input logic [demodCtrlPkg::AddrWidth-1:0] a
  );
    if (a >= demodCtrlPkg::MiscSpaceLo && a <= demodCtrlPkg::MiscSpaceHi)
      return demodCtrlPkg::SpaceMisc;
    if (a >= demodCtrlPkg::DacSpaceLo && a <= demodCtrlPkg::DacSpaceHi)
      return demodCtrlPkg::SpaceDac;
    if (a >= demodCtrlPkg::GpioSpaceLo && a <= demodCtrlPkg::GpioSpaceHi)
      return demodCtrlPkg::SpaceGpio;
    if (a >= demodCtrlPkg::DemodSpaceLo && a <= demodCtrlPkg::DemodSpaceHi)
      return demodCtrlPkg::SpaceDemod;
    return demodCtrlPkg::SpaceNone;
  endfunction

  assign busSpace = decodeSpace(busQ.addr);
  assign wrSampled = !busQ.nCs && !busQ.nWe;
  assign rdSampled = !busQ.nCs && !busQ.nRd;

  // ********************
  // Read mux
  // ********************
  always_comb begin
    rdMux = '0;
    case (busSpace)
      demodCtrlPkg::SpaceMisc:
        if (busQ.addr == demodCtrlPkg::MiscVersionAddr) rdMux = demodCtrlPkg::VerNumber;
      demodCtrlPkg::SpaceDac:
        if (busQ.addr == demodCtrlPkg::DacCtrlAddr) rdMux = dacRdData;
      demodCtrlPkg::SpaceGpio:
        if (busQ.addr == demodCtrlPkg::GpioAddr) rdMux = gpioRdData;
      // Demod registers are 32 bits, addr[1] picks the half
      demodCtrlPkg::SpaceDemod:
        rdMux = busQ.addr[1] ? demodRdData[31:16] : demodRdData[15:0];
      default:
        rdMux = '0;
    endcase
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      busQ <= '{nCs: 1'b1, nWe: 1'b1, nRd: 1'b1, default: '0};
      wrPrev <= 1'b0;
      regWrite <= '0;
      space <= demodCtrlPkg::SpaceNone;
      rdOe <= 1'b0;
      rdData <= '0;
    end else begin
      busQ <= hostBus;
      wrPrev <= wrSampled;
      // One strobe on the first sampled write cycle only
      regWrite.strobe <= wrSampled && !wrPrev;
      regWrite.addr <= busQ.addr;
      regWrite.data <= busQ.wrData;
      space <= busSpace;
      rdOe <= rdSampled;
      rdData <= rdMux;
    end
  end

  assign softReset = regWrite.strobe && (space == demodCtrlPkg::SpaceMisc) &&
                     (regWrite.addr == demodCtrlPkg::MiscResetAddr);

  assert property (@(posedge ck933) disable iff (rs)
    regWrite.strobe |=> !regWrite.strobe);

endmodule

// ==== hw/resetStretcher.sv ====
/*
 * Stretches a one-cycle soft reset strobe into an internal reset
 * that is held for a fixed number of cycles. rs forces it at once.
 */
module resetStretcher (
  input  logic ck933,
  input  logic rs,
  input  logic softReset,
  output logic intReset
);

  localparam int CntWidth = $clog2(demodCtrlPkg::ResetHoldCycles + 1);

  logic [CntWidth-1:0] holdCnt;
  logic holdQ;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      holdCnt <= '0;
      holdQ <= 1'b1;
    end else begin
      if (softReset) begin
        holdCnt <= CntWidth'(demodCtrlPkg::ResetHoldCycles);
      end else if (holdCnt != '0) begin
        holdCnt <= holdCnt - 1'b1;
      end
      // High while loaded or still counting down
      holdQ <= softReset || (holdCnt != '0);
    end
  end

  assign intReset = holdQ;

  // Full hold once the strobe lands
  assert property (@(posedge ck933) disable iff (rs)
    softReset |=> intReset [*demodCtrlPkg::ResetHoldCycles + 1]);

endmodule

// ==== hw/spiBitTimer.sv ====
/*
 * Divides ck933 by four into the serial clock. Each bit is two cycles
 * low then two high, with ticks for shifting and sampling.
 */
module spiBitTimer (
  input  logic ck933,
  input  logic rs,
  input  logic run,
  output logic sclk,
  output logic shiftTick,
  output logic sampleTick
);

  logic [1:0] phase;

  // Phase 0 and 1 low, 2 and 3 high
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      phase <= '0;
    end else if (run) begin
      phase <= phase + 1'b1;
    end else begin
      phase <= '0;
    end
  end

  assign sclk = phase[1];

  // Shift lands on the falling edge, capture on the rising edge
  assign shiftTick = run && (phase == 2'd3);
  assign sampleTick = run && (phase == 2'd1);

endmodule

// ==== hw/spiShifter.sv ====
/*
 * Serializes one frame MSB first onto sdio and collects the read-back
 * byte from the DAC while capture is enabled.
 */
module spiShifter (
  input  logic ck933,
  input  logic rs,
  input  logic load,
  input  demodCtrlPkg::spiFrame_t frame,
  input  logic shiftTick,
  input  logic sampleTick,
  input  logic captureEn,
  input  logic sdioIn,
  output logic sdioOut,
  output logic [7:0] readByte
);

  logic [demodCtrlPkg::SpiFrameBits-1:0] shiftReg;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      shiftReg <= '0;
    end else if (load) begin
      shiftReg <= frame;
    end else if (shiftTick) begin
      shiftReg <= {shiftReg[demodCtrlPkg::SpiFrameBits-2:0], 1'b0};
    end
  end

  assign sdioOut = shiftReg[demodCtrlPkg::SpiFrameBits-1];

  // Read-back byte arrives MSB first
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      readByte <= '0;
    end else if (sampleTick && captureEn) begin
      readByte <= {readByte[6:0], sdioIn};
    end
  end

endmodule

// ==== hw/statusGpio.sv ====
/*
 * General purpose output register written from the host. Bits 0 and 1
 * drive the two lock indicator pins, and the whole word reads back.
 */
module statusGpio (
  input  logic ck933,
  input  logic rs,
  input  demodCtrlPkg::regWrite_t regWrite,
  input  demodCtrlPkg::addrSpace_e space,
  output logic [15:0] gpioRdData,
  output logic bsyncNLock,
  output logic demodNLock
);

  logic [15:0] gpioReg;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      gpioReg <= '0;
    end else if (regWrite.strobe && space == demodCtrlPkg::SpaceGpio) begin
      gpioReg <= regWrite.data;
    end
  end

  assign gpioRdData = gpioReg;

  // Lock pins, bit 0 bit sync and bit 1 demod
  assign bsyncNLock = gpioReg[0];
  assign demodNLock = gpioReg[1];

endmodule

// ==== verification/demodCtrlTasks.svh ====
/*
 * Host bus access, serial port monitor and directed test tasks.
 * Included inside the testbench module, uses its signals directly.
 */
`ifndef DEMOD_CTRL_TASKS_SVH
`define DEMOD_CTRL_TASKS_SVH

  // ********************
  // Checking helpers
  // ********************
  task automatic checkHex(input string sigName, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h", sigName, got, exp);
      errCount++;
    end
  endtask

  task automatic noteProblem(input string what);
    $display("ERROR: %s", what);
    errCount++;
  endtask

  task automatic finishTest(input string testName, input int errStart);
    testCount++;
    if (errCount == errStart) begin
      $display("test %s: ok", testName);
    end else begin
      failedTests++;
      $display("test %s: %0d check(s) wrong", testName, errCount - errStart);
    end
  endtask

  // ********************
  // Host bus access
  // ********************
  // Each access held for 4 cycles
  task automatic hostWrite(input logic [11:0] addr, input logic [15:0] data);
    @(negedge ck933);
    hostBus.nCs = 1'b0;
    hostBus.nWe = 1'b0;
    hostBus.nRd = 1'b1;
    hostBus.addr = addr;
    hostBus.wrData = data;
    repeat (4) @(negedge ck933);
    hostBus.nCs = 1'b1;
    hostBus.nWe = 1'b1;
  endtask

  task automatic hostRead(input logic [11:0] addr, output logic [15:0] data,
                          output logic oe);
    @(negedge ck933);
    hostBus.nCs = 1'b0;
    hostBus.nWe = 1'b1;
    hostBus.nRd = 1'b0;
    hostBus.addr = addr;
    // Read data is valid two cycles after the drive
    repeat (3) @(negedge ck933);
    data = rdData;
    oe = rdOe;
    @(negedge ck933);
    hostBus.nCs = 1'b1;
    hostBus.nRd = 1'b1;
  endtask

  // Polls the DAC status word until busy clears
  task automatic waitIdle(output logic [15:0] status);
    logic oe;
    int polls;
    polls = 0;
    status = 16'h0001;
    while (status[0] && polls < 30) begin
      hostRead(demodCtrlPkg::DacCtrlAddr, status, oe);
      polls++;
    end
    assert (!status[0]) else noteProblem("busy did not clear after 30 status polls");
  endtask

  // Collects sdioOut at each sclk rise, drives the reply byte for read frames
  task automatic spiMonitor(input int channel, input logic readMode,
                            input logic [7:0] replyByte, output logic [15:0] bits);
    int waitCycles;
    int bitIdx;
    int cyc;
    int lastRise;
    logic prevSclk;
    logic [2:0] selCs;
    bits = '0;
    // All selects idle high except the chosen one
    selCs = 3'b111;
    selCs[channel] = 1'b0;
    waitCycles = 0;
    while (csN === 3'b111 && waitCycles < 40) begin
      @(negedge ck933);
      waitCycles++;
    end
    assert (csN !== 3'b111) else noteProblem("no chip select went low within 40 cycles");
    bitIdx = 0;
    cyc = 0;
    lastRise = -1;
    prevSclk = sclk;
    while (csN !== 3'b111 && bitIdx < 16 && cyc < 100) begin
      checkHex("csN", csN, selCs);
      if (readMode && bitIdx >= 8 && !sclk) begin
        sdioIn = replyByte[15 - bitIdx];
      end
      if (sclk && !prevSclk) begin
        bits = {bits[14:0], sdioOut};
        checkHex("sdioOe", sdioOe, !(readMode && bitIdx >= 8));
        if (lastRise >= 0) begin
          checkHex("sclk period", cyc - lastRise, 4);
        end
        lastRise = cyc;
        bitIdx++;
      end
      prevSclk = sclk;
      @(negedge ck933);
      cyc++;
    end
    sdioIn = 1'b0;
    assert (bitIdx == 16) else
      noteProblem($sformatf("only %0d serial bits seen before chip select rose", bitIdx));
  endtask

  // ********************
  // Directed tests
  // ********************
  task automatic testVersionRead();
    logic [15:0] data;
    logic oe;
    int errStart;
    errStart = errCount;
    hostRead(demodCtrlPkg::MiscVersionAddr, data, oe);
    checkHex("rdData", data, 16'h0003);
    checkHex("rdOe", oe, 1'b1);
    hostRead(12'h400, data, oe);
    checkHex("rdData", data, 16'h0000);
    checkHex("rdOe", oe, 1'b1);
    finishTest("version and unmapped read", errStart);
  endtask

  task automatic testGpioReadback();
    logic [15:0] value;
    logic [15:0] data;
    logic oe;
    int errStart;
    errStart = errCount;
    value = 16'($urandom);
    hostWrite(demodCtrlPkg::GpioAddr, value);
    hostRead(demodCtrlPkg::GpioAddr, data, oe);
    checkHex("gpio rdData", data, value);
    checkHex("bsyncNLock", bsyncNLock, value[0]);
    checkHex("demodNLock", demodNLock, value[1]);
    finishTest("gpio readback", errStart);
  endtask

  task automatic measureResetPulse(output int highCycles);
    int waitCycles;
    waitCycles = 0;
    highCycles = 0;
    while (!dacRst && waitCycles < 20) begin
      @(negedge ck933);
      waitCycles++;
    end
    while (dacRst && highCycles < 50) begin
      @(negedge ck933);
      highCycles++;
    end
  endtask

  task automatic testSoftReset();
    logic [15:0] data;
    logic oe;
    int highCycles;
    int errStart;
    errStart = errCount;
    // Lock pins set first so the clear is visible
    hostWrite(demodCtrlPkg::GpioAddr, 16'($urandom) | 16'h0003);
    fork
      hostWrite(demodCtrlPkg::MiscResetAddr, 16'($urandom));
      measureResetPulse(highCycles);
    join
    assert (highCycles >= demodCtrlPkg::ResetHoldCycles && highCycles < 50) else
      noteProblem($sformatf("dacRst was high for %0d cycles", highCycles));
    hostRead(demodCtrlPkg::GpioAddr, data, oe);
    checkHex("gpio rdData", data, 16'h0000);
    checkHex("bsyncNLock", bsyncNLock, 1'b0);
    checkHex("demodNLock", demodNLock, 1'b0);
    finishTest("soft reset", errStart);
  endtask

  task automatic testSpiWrite();
    logic [15:0] frame;
    logic [15:0] bits;
    logic [15:0] status;
    int errStart;
    errStart = errCount;
    for (int ch = 0; ch < 3; ch++) begin
      frame = 16'($urandom) & 16'h7FFF;
      hostWrite(demodCtrlPkg::DacFrameAddr, frame);
      fork
        hostWrite(demodCtrlPkg::DacCtrlAddr, 16'(ch));
        spiMonitor(ch, 1'b0, 8'h00, bits);
      join
      checkHex("sdioOut frame", bits, frame);
      waitIdle(status);
      checkHex("status busy", status[0], 1'b0);
      checkHex("csN", csN, 3'b111);
    end
    finishTest("spi write frames", errStart);
  endtask

  task automatic testSpiRead();
    logic [15:0] frame;
    logic [15:0] bits;
    logic [15:0] status;
    logic [7:0] reply;
    int errStart;
    errStart = errCount;
    frame = 16'($urandom) | 16'h8000;
    reply = 8'($urandom);
    hostWrite(demodCtrlPkg::DacFrameAddr, frame);
    fork
      hostWrite(demodCtrlPkg::DacCtrlAddr, 16'd1);
      spiMonitor(1, 1'b1, reply, bits);
    join
    // Only the command byte is ours on a read frame
    checkHex("sdioOut command", bits[15:8], frame[15:8]);
    waitIdle(status);
    checkHex("status readBack", status[15:8], reply);
    finishTest("spi read frame", errStart);
  endtask

  task automatic catchDemodWrite(output logic [11:0] addr, output logic [15:0] data,
                                 output logic seen);
    int waitCycles;
    waitCycles = 0;
    seen = 1'b0;
    while (!seen && waitCycles < 10) begin
      @(negedge ck933);
      waitCycles++;
      seen = demodWrite.strobe;
    end
    addr = demodWrite.addr;
    data = demodWrite.data;
  endtask

  task automatic testConverterDemod();
    logic [17:0] s;
    logic [2:0][13:0] expWord;
    logic [13:0] adc;
    logic [11:0] addr;
    logic [11:0] gotAddr;
    logic [15:0] data;
    logic [15:0] gotData;
    logic seen;
    logic oe;
    int errStart;
    errStart = errCount;
    for (int i = 0; i < 4; i++) begin
      @(negedge ck933);
      for (int k = 0; k < 3; k++) begin
        s = 18'($urandom);
        samples.sample[k] = s;
        // Offset binary is the two's complement word plus half scale
        expWord[k] = s[17:4] + 14'h2000;
      end
      samples.sync = 3'b111;
      adc = 14'($urandom);
      adcD = adc;
      @(negedge ck933);
      checkHex("ifSample", ifSample, adc);
      for (int k = 0; k < 3; k++) begin
        checkHex($sformatf("dacD[%0d]", k), dacD[k], expWord[k]);
      end
      // New samples without sync must not reach the outputs
      samples.sync = 3'b000;
      for (int k = 0; k < 3; k++) begin
        samples.sample[k] = 18'($urandom);
      end
      @(negedge ck933);
      for (int k = 0; k < 3; k++) begin
        checkHex($sformatf("dacD[%0d] hold", k), dacD[k], expWord[k]);
      end
    end

    // Demodulator register write forwarding
    addr = {1'b1, 10'($urandom), 1'b0};
    data = 16'($urandom);
    fork
      hostWrite(addr, data);
      catchDemodWrite(gotAddr, gotData, seen);
    join
    assert (seen) else noteProblem("no strobe on demodWrite after a demod space write");
    checkHex("demodWrite.addr", gotAddr, addr);
    checkHex("demodWrite.data", gotData, data);

    // Read halves chosen by address bit 1
    demodRdData = $urandom;
    hostRead({1'b1, 9'($urandom), 2'b10}, data, oe);
    checkHex("demod upper rdData", data, demodRdData[31:16]);
    hostRead({1'b1, 9'($urandom), 2'b00}, data, oe);
    checkHex("demod lower rdData", data, demodRdData[15:0]);
    checkHex("rdOe", oe, 1'b1);
    finishTest("converter and demod paths", errStart);
  endtask

`endif

// ==== verification/demodCtrlTb.sv ====
/*
 * Testbench top for the demodulator host control subsystem. Runs the
 * directed tests from demodCtrlTasks.svh against demodCtrlTop.
 */
module demodCtrlTb;

  // Six tests take well under 1000 cycles, four serial transfers included
  localparam int TimeoutCycles = 3000;

  logic ck933 = 1'b0;
  logic rs;
  demodCtrlPkg::hostBus_t hostBus;
  logic [15:0] rdData;
  logic rdOe;
  logic [13:0] adcD;
  logic [13:0] ifSample;
  demodCtrlPkg::demodSamples_t samples;
  logic [2:0][13:0] dacD;
  logic dacRst;
  logic [2:0] csN;
  logic sclk;
  logic sdioIn;
  logic sdioOut;
  logic sdioOe;
  logic bsyncNLock;
  logic demodNLock;
  demodCtrlPkg::regWrite_t demodWrite;
  logic [31:0] demodRdData;

  int errCount = 0;
  int testCount = 0;
  int failedTests = 0;
  int cycleCount = 0;

  always #2 ck933 = ~ck933;

  demodCtrlTop DUT (
    .ck933(ck933),
    .rs(rs),
    .hostBus(hostBus),
    .rdData(rdData),
    .rdOe(rdOe),
    .adcD(adcD),
    .ifSample(ifSample),
    .samples(samples),
    .dacD(dacD),
    .dacRst(dacRst),
    .csN(csN),
    .sclk(sclk),
    .sdioIn(sdioIn),
    .sdioOut(sdioOut),
    .sdioOe(sdioOe),
    .bsyncNLock(bsyncNLock),
    .demodNLock(demodNLock),
    .demodWrite(demodWrite),
    .demodRdData(demodRdData)
  );

  `include "demodCtrlTasks.svh"

  // ********************
  // Test sequence
  // ********************
  initial begin
    rs = 1'b1;
    hostBus = '{nCs: 1'b1, nWe: 1'b1, nRd: 1'b1, default: '0};
    adcD = '0;
    samples = '0;
    sdioIn = 1'b0;
    demodRdData = '0;
    void'($urandom(32'h467c57c6));

    repeat (10) @(negedge ck933);
    rs = 1'b0;
    repeat (2) @(negedge ck933);

    testVersionRead();
    testGpioReadback();
    testSoftReset();
    testSpiWrite();
    testSpiRead();
    testConverterDemod();

    $display("Tests run %0d, tests failed %0d, checks failed %0d",
             testCount, failedTests, errCount);
    if (errCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin
    while (cycleCount < TimeoutCycles) begin
      @(posedge ck933);
      cycleCount++;
    end
    $display("Run stopped after %0d cycles before the tests completed", cycleCount);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/demodCtrlPkg.sv
hw/resetStretcher.sv
hw/spiBitTimer.sv
hw/spiShifter.sv
hw/dacSpiSequencer.sv
hw/hostBusDecoder.sv
hw/converterIo.sv
hw/statusGpio.sv
hw/demodCtrlTop.sv
+incdir+verification
verification/demodCtrlTb.sv
